// ==== build.f ====
+incdir+common
common/lsab_pkg.sv
lsab/lsab_occupancy.sv
lsab/lsab_port_mux.sv
lsab/lsab_sram.sv
lsab/lsab_read_return.sv
lsab/lsab_top.sv
verif/lsab_checker.sv
verif/lsab_tb.sv

// ==== Bender.yml ====
package:
  name: lsab

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lsab_pkg.sv
      - lsab/lsab_occupancy.sv
      - lsab/lsab_port_mux.sv
      - lsab/lsab_sram.sv
      - lsab/lsab_read_return.sv
      - lsab/lsab_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/lsab_checker.sv
      - verif/lsab_tb.sv

// ==== verif/lsab_tb.sv ====
`timescale 1ns/1ps

module lsab_tb;
  localparam int OP_IDLE = 0;
  localparam int OP_WR   = 1;
  localparam int OP_RD   = 2;
  localparam int OP_RW   = 3;

  logic            CLK;
  logic            RST;
  logic            read;
  logic            write;
  lsab_pkg::fifo_t read_fifo;
  lsab_pkg::fifo_t write_fifo;
  lsab_pkg::data_t in;
  lsab_pkg::data_t out_0;
  lsab_pkg::data_t out_1;
  lsab_pkg::data_t out_2;
  lsab_pkg::data_t out_3;
  logic            bfull_0;
  logic            bfull_1;
  logic            bfull_2;
  logic            bfull_3;
  logic [8*16-1:0] cur_name;
  logic [31:0]     data_errors;
  logic [31:0]     flag_errors;

  logic [8*16-1:0] row_name [32];
  int              row_op [32];
  lsab_pkg::fifo_t row_wf [32];
  lsab_pkg::fifo_t row_rf [32];
  int              row_n [32];
  int              nrows;
  int              cycles;
  int              limit;
  logic [31:0]     lfsr;

  lsab_top uut (
    .CLK(CLK), .RST(RST), .read(read), .write(write),
    .read_fifo(read_fifo), .write_fifo(write_fifo), .in(in),
    .out_0(out_0), .out_1(out_1), .out_2(out_2), .out_3(out_3),
    .bfull_0(bfull_0), .bfull_1(bfull_1), .bfull_2(bfull_2), .bfull_3(bfull_3)
  );

  lsab_checker u_chk (
    .CLK(CLK), .RST(RST), .read(read), .write(write),
    .read_fifo(read_fifo), .write_fifo(write_fifo), .in(in),
    .out_0(out_0), .out_1(out_1), .out_2(out_2), .out_3(out_3),
    .bfull_0(bfull_0), .bfull_1(bfull_1), .bfull_2(bfull_2), .bfull_3(bfull_3),
    .test_name(cur_name), .data_errors(data_errors), .flag_errors(flag_errors)
  );

  always #4 CLK = ~CLK;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_word(output lsab_pkg::data_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic add_row(input logic [8*16-1:0] name, input int op, input int wf,
                         input int rf, input int n);
    row_name[nrows] = name;
    row_op[nrows]   = op;
    row_wf[nrows]   = lsab_pkg::fifo_t'(wf);
    row_rf[nrows]   = lsab_pkg::fifo_t'(rf);
    row_n[nrows]    = n;
    nrows           = nrows + 1;
  endtask

  // one table entry per cycle, driven on the falling edge
  task automatic apply_row(input int r);
    cur_name   = row_name[r];
    write_fifo = row_wf[r];
    read_fifo  = row_rf[r];
    for (int i = 0; i < row_n[r]; i++) begin
      write = (row_op[r] == OP_WR) || (row_op[r] == OP_RW);
      read  = (row_op[r] == OP_RD) || (row_op[r] == OP_RW);
      if (write) begin
        next_word(in);
      end
      @(negedge CLK);
    end
  endtask

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    CLK        = 1'b0;
    RST        = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    read_fifo  = '0;
    write_fifo = '0;
    in         = '0;
    cur_name   = "reset";
    lfsr       = 32'haa1;
    cycles     = 0;
    nrows      = 0;
    add_row("reset_idle", OP_IDLE, 0, 0, 2);
    add_row("order_wr", OP_WR, 0, 0, 8);
    add_row("order_rd", OP_RD, 0, 0, 8);
    add_row("mix_wr_f1", OP_WR, 1, 0, 4);
    add_row("mix_wr_f3", OP_WR, 3, 0, 4);
    add_row("mix_rw_a", OP_RW, 0, 1, 4);  // write f0, read f1
    add_row("mix_rw_b", OP_RW, 2, 3, 4);
    add_row("mix_rd_f0", OP_RD, 0, 0, 4);
    add_row("mix_rd_f2", OP_RD, 0, 2, 4);
    add_row("almost_fill", OP_WR, 2, 0, 56);
    add_row("almost_rd", OP_RD, 0, 2, 1);
    add_row("almost_drain", OP_RD, 0, 2, 55);
    add_row("overflow_wr", OP_WR, 1, 0, 70);
    add_row("overflow_rd", OP_RD, 0, 1, 64);  // last one refused
    add_row("same_fill", OP_WR, 3, 0, 57);
    add_row("same_rw", OP_RW, 3, 3, 6);
    add_row("same_drain", OP_RD, 0, 3, 58);
    add_row("drain_idle", OP_IDLE, 0, 0, 4);
    limit = 16;
    for (int r = 0; r < nrows; r++) begin
      limit = limit + row_n[r];
    end
    limit = limit + 16;

    repeat (16) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
    for (int r = 0; r < nrows; r++) begin
      apply_row(r);
    end

    $display("checks done: %0d data errors, %0d flag errors", data_errors, flag_errors);
    if (data_errors + flag_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/lsab_checker.sv ====
`timescale 1ns/1ps
`include "lsab_defs.svh"

module lsab_checker (
  input  logic            CLK,
  input  logic            RST,
  input  logic            read,
  input  logic            write,
  input  lsab_pkg::fifo_t read_fifo,
  input  lsab_pkg::fifo_t write_fifo,
  input  lsab_pkg::data_t in,
  input  lsab_pkg::data_t out_0,
  input  lsab_pkg::data_t out_1,
  input  lsab_pkg::data_t out_2,
  input  lsab_pkg::data_t out_3,
  input  logic            bfull_0,
  input  logic            bfull_1,
  input  logic            bfull_2,
  input  logic            bfull_3,
  input  logic [8*16-1:0] test_name,
  output logic [31:0]     data_errors,
  output logic [31:0]     flag_errors
);
  lsab_pkg::data_t model [`LSAB_FIFOS][64];
  int              head [`LSAB_FIFOS];
  int              count [`LSAB_FIFOS];
  lsab_pkg::data_t exp_out [`LSAB_FIFOS];
  logic            exp_bfull [`LSAB_FIFOS];
  logic            pend_v;  // read accepted last edge
  lsab_pkg::fifo_t pend_f;
  lsab_pkg::data_t pend_w;

  initial begin
    data_errors = 0;
    flag_errors = 0;
    pend_v      = 1'b0;
  end

  function automatic lsab_pkg::data_t dut_word(input int k);
    case (k)
      0:       return out_0;
      1:       return out_1;
      2:       return out_2;
      default: return out_3;
    endcase
  endfunction

  function automatic logic dut_flag(input int k);
    case (k)
      0:       return bfull_0;
      1:       return bfull_1;
      2:       return bfull_2;
      default: return bfull_3;
    endcase
  endfunction

  task automatic compare_outputs();
    for (int k = 0; k < `LSAB_FIFOS; k++) begin
      if (dut_word(k) !== exp_out[k]) begin
        data_errors = data_errors + 1;
        $display("FAIL %0s out_%0d expected %h actual %h",
                 test_name, k, exp_out[k], dut_word(k));
      end
      if (dut_flag(k) !== exp_bfull[k]) begin
        flag_errors = flag_errors + 1;
        $display("FAIL %0s bfull_%0d expected %0b actual %0b",
                 test_name, k, exp_bfull[k], dut_flag(k));
      end
    end
  endtask

  // outputs seen here are the values left by the previous edge
  always @(posedge CLK) begin : model_step
    logic wr_ok;
    logic rd_ok;
    int   tail;
    if (!RST) begin
      for (int k = 0; k < `LSAB_FIFOS; k++) begin
        exp_out[k]   = '0;
        exp_bfull[k] = 1'b0;
        head[k]      = 0;
        count[k]     = 0;
      end
      pend_v = 1'b0;
    end else begin
      compare_outputs();
      if (pend_v) begin
        exp_out[pend_f] = pend_w;  // lands one edge after acceptance
      end
      wr_ok  = write && (count[write_fifo] != `LSAB_FULL_LEN);
      rd_ok  = read && (count[read_fifo] != 0);
      pend_v = rd_ok;
      if (rd_ok) begin
        pend_f           = read_fifo;
        pend_w           = model[read_fifo][head[read_fifo]];
        head[read_fifo]  = (head[read_fifo] + 1) % 64;
        count[read_fifo] = count[read_fifo] - 1;
      end
      if (wr_ok) begin
        tail                     = (head[write_fifo] + count[write_fifo]) % 64;
        model[write_fifo][tail]  = in;
        count[write_fifo]        = count[write_fifo] + 1;
      end
      for (int k = 0; k < `LSAB_FIFOS; k++) begin
        exp_bfull[k] = (count[k] >= `LSAB_ALMOST_LEN);
      end
    end
  end

endmodule

// ==== lsab/lsab_top.sv ====
`timescale 1ns/1ps
`include "lsab_defs.svh"

module lsab_top (
  input  logic             CLK,
  input  logic             RST,
  input  logic             read,
  input  logic             write,
  input  lsab_pkg::fifo_t  read_fifo,
  input  lsab_pkg::fifo_t  write_fifo,
  input  lsab_pkg::data_t  in,
  output lsab_pkg::data_t  out_0,
  output lsab_pkg::data_t  out_1,
  output lsab_pkg::data_t  out_2,
  output lsab_pkg::data_t  out_3,
  output logic             bfull_0,
  output logic             bfull_1,
  output logic             bfull_2,
  output logic             bfull_3
);
  logic [`LSAB_FIFOS-1:0] push_req;
  logic [`LSAB_FIFOS-1:0] pop_req;
  logic [`LSAB_FIFOS-1:0] push_ok;
  logic [`LSAB_FIFOS-1:0] pop_ok;
  logic [`LSAB_FIFOS-1:0] bfull;
  lsab_pkg::slot_t        wr_slot [`LSAB_FIFOS];
  lsab_pkg::slot_t        rd_slot [`LSAB_FIFOS];
  logic                   we;
  logic                   re;
  lsab_pkg::sram_addr_u   waddr;
  lsab_pkg::sram_addr_u   raddr;
  lsab_pkg::data_t        rdata;

  lsab_port_mux u_mux (
    .read       (read),
    .write      (write),
    .read_fifo  (read_fifo),
    .write_fifo (write_fifo),
    .push_ok    (push_ok),
    .pop_ok     (pop_ok),
    .wr_slot    (wr_slot),
    .rd_slot    (rd_slot),
    .push_req   (push_req),
    .pop_req    (pop_req),
    .we         (we),
    .re         (re),
    .waddr      (waddr),
    .raddr      (raddr)
  );

  for (genvar i = 0; i < `LSAB_FIFOS; i++) begin : g_occ
    lsab_occupancy u_occ (
      .CLK      (CLK),
      .RST      (RST),
      .push_req (push_req[i]),
      .pop_req  (pop_req[i]),
      .push_ok  (push_ok[i]),
      .pop_ok   (pop_ok[i]),
      .bfull    (bfull[i]),
      .wr_slot  (wr_slot[i]),
      .rd_slot  (rd_slot[i])
    );
  end

  lsab_sram u_sram (
    .CLK   (CLK),
    .we    (we),
    .re    (re),
    .waddr (waddr),
    .raddr (raddr),
    .wdata (in),
    .rdata (rdata)
  );

  lsab_read_return u_ret (
    .CLK       (CLK),
    .RST       (RST),
    .re        (re),
    .read_fifo (read_fifo),
    .rdata     (rdata),
    .out_0     (out_0),
    .out_1     (out_1),
    .out_2     (out_2),
    .out_3     (out_3)
  );

  assign bfull_0 = bfull[0];
  assign bfull_1 = bfull[1];
  assign bfull_2 = bfull[2];
  assign bfull_3 = bfull[3];

endmodule

// ==== lsab/lsab_read_return.sv ====
`timescale 1ns/1ps

module lsab_read_return (
  input  logic            CLK,
  input  logic            RST,
  input  logic            re,
  input  lsab_pkg::fifo_t read_fifo,
  input  lsab_pkg::data_t rdata,
  output lsab_pkg::data_t out_0,
  output lsab_pkg::data_t out_1,
  output lsab_pkg::data_t out_2,
  output lsab_pkg::data_t out_3
);
  logic            re_d;
  lsab_pkg::fifo_t fifo_d;

  // match the sram read latency
  always_ff @(posedge CLK) begin
    if (!RST) begin
      re_d   <= 1'b0;
      fifo_d <= '0;
    end else begin
      re_d   <= re;
      fifo_d <= read_fifo;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      out_0 <= '0;
      out_1 <= '0;
      out_2 <= '0;
      out_3 <= '0;
    end else if (re_d) begin
      case (fifo_d)
        2'd0:    out_0 <= rdata;
        2'd1:    out_1 <= rdata;
        2'd2:    out_2 <= rdata;
        default: out_3 <= rdata;
      endcase
    end
  end

endmodule

// ==== lsab/lsab_sram.sv ====
`timescale 1ns/1ps
`include "lsab_defs.svh"

module lsab_sram (
  input  logic                 CLK,
  input  logic                 we,
  input  logic                 re,
  input  lsab_pkg::sram_addr_u waddr,
  input  lsab_pkg::sram_addr_u raddr,
  input  lsab_pkg::data_t      wdata,
  output lsab_pkg::data_t      rdata
);
  lsab_pkg::data_t mem [2**`LSAB_ADDR_W];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr.flat] <= wdata;
    end
  end

  // read word held until the next enabled read
  always_ff @(posedge CLK) begin
    if (re) begin
      rdata <= mem[raddr.flat];
    end
  end

endmodule

// ==== lsab/lsab_port_mux.sv ====
`timescale 1ns/1ps
`include "lsab_defs.svh"

module lsab_port_mux (
  input  logic                   read,
  input  logic                   write,
  input  lsab_pkg::fifo_t        read_fifo,
  input  lsab_pkg::fifo_t        write_fifo,
  input  logic [`LSAB_FIFOS-1:0] push_ok,
  input  logic [`LSAB_FIFOS-1:0] pop_ok,
  input  lsab_pkg::slot_t        wr_slot [`LSAB_FIFOS],
  input  lsab_pkg::slot_t        rd_slot [`LSAB_FIFOS],
  output logic [`LSAB_FIFOS-1:0] push_req,
  output logic [`LSAB_FIFOS-1:0] pop_req,
  output logic                   we,
  output logic                   re,
  output lsab_pkg::sram_addr_u   waddr,
  output lsab_pkg::sram_addr_u   raddr
);

  // one-hot request per fifo
  always_comb begin
    push_req             = '0;
    pop_req              = '0;
    push_req[write_fifo] = write;
    pop_req[read_fifo]   = read;
  end

  // the occupancy counters decide acceptance
  assign we = push_ok[write_fifo];
  assign re = pop_ok[read_fifo];

  always_comb begin
    waddr.field.fifo = write_fifo;
    waddr.field.slot = wr_slot[write_fifo];
  end

  always_comb begin
    raddr.field.fifo = read_fifo;
    raddr.field.slot = rd_slot[read_fifo];  // oldest entry
  end

endmodule

// ==== lsab/lsab_occupancy.sv ====
`timescale 1ns/1ps
`include "lsab_defs.svh"

module lsab_occupancy (
  input  logic            CLK,
  input  logic            RST,
  input  logic            push_req,
  input  logic            pop_req,
  output logic            push_ok,
  output logic            pop_ok,
  output logic            bfull,
  output lsab_pkg::slot_t wr_slot,
  output lsab_pkg::slot_t rd_slot
);
  lsab_pkg::len_t len;
  lsab_pkg::len_t len_nxt;
  logic           full;
  logic           empty;

  assign push_ok = push_req && !full;  // full write just vanishes
  assign pop_ok  = pop_req && !empty;

  always_comb begin
    case ({push_ok, pop_ok})
      2'b10:   len_nxt = len + 1'b1;
      2'b01:   len_nxt = len - 1'b1;
      default: len_nxt = len;  // idle, or push and pop together
    endcase
  end

  // flags are registered off the next length so they move with it
  always_ff @(posedge CLK) begin
    if (!RST) begin
      len   <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
      bfull <= 1'b0;
    end else begin
      len   <= len_nxt;
      full  <= (len_nxt == `LSAB_FULL_LEN);
      empty <= (len_nxt == 0);
      bfull <= (len_nxt >= `LSAB_ALMOST_LEN);
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      wr_slot <= '0;
      rd_slot <= '0;
    end else begin
      if (push_ok) begin
        wr_slot <= wr_slot + 1'b1;  // wraps at 64
      end
      if (pop_ok) begin
        rd_slot <= rd_slot + 1'b1;
      end
    end
  end

endmodule

// ==== common/lsab_pkg.sv ====
`include "lsab_defs.svh"

package lsab_pkg;

  typedef logic [`LSAB_DATA_W-1:0] data_t;
  typedef logic [`LSAB_FIFO_W-1:0] fifo_t;
  typedef logic [`LSAB_SLOT_W-1:0] slot_t;
  typedef logic [`LSAB_SLOT_W-1:0] len_t;

  // fifo index in the top bits, slot below
  typedef struct packed {
    fifo_t fifo;
    slot_t slot;
  } sram_field_t;

  typedef union packed {
    logic [`LSAB_ADDR_W-1:0] flat;
    sram_field_t             field;
  } sram_addr_u;

endpackage

// ==== common/lsab_defs.svh ====
`ifndef LSAB_DEFS_SVH
`define LSAB_DEFS_SVH

`define LSAB_DATA_W     32
`define LSAB_FIFOS      4
`define LSAB_FIFO_W     2
`define LSAB_SLOT_W     6
`define LSAB_ADDR_W     8

// one slot stays unused so the wrapping pointers never alias
`define LSAB_FULL_LEN   63

// early warning for the writer
`define LSAB_ALMOST_LEN 56

`endif
